/* hw/mr_glue_pkg.sv */
/* Shared layout of the OSD status word, bus widths and crop constants.
   Imported by every module of the settings and player-input glue. */
package mr_glue_pkg;

    localparam int STATUS_W = 64;
    localparam int MENU_W   = 16;

    // Status bit that enables the UART, also the low bit of user_mode
    localparam int UART_EN_BIT = 38;

    // Extension port
    localparam int            USER_W      = 7;
    localparam logic [6:0]    USER_IDLE   = 7'h7f;
    localparam int            UART_RX_BIT = 1;

    // PS/2 mouse packet from the HPS
    localparam int MOUSE_PKT_W = 25;
    localparam int MOUSE_D_W   = 9;
    localparam int MOUSE_F_W   = 8;

    // HDMI output geometry
    localparam int HDMI_DIM_W = 12;
    localparam int FULL_HD_W  = 1920;
    localparam int FULL_HD_H  = 1080;

    // Vertical crop for 1080p, offset is -16..+15 lines
    localparam int CROP_SIZE_W = 12;
    localparam int CROP_OFF_W  = 5;
    localparam int CROP_LINES  = 216;
    localparam int VCOPT_WRAP  = 6;
    localparam int VCOPT_BIAS  = 24;

    // user_mode value asking for a frame buffer flip
    localparam int FLIP_MODE = 2;

    // Field layout of the status word, MSB first
    typedef struct packed {
        logic [2:0]  rsvd_63;
        logic [3:0]  voffset;
        logic [3:0]  hoffset;
        logic [3:0]  hsize_scale;
        logic        hsize_en;
        logic [1:0]  crop_scale;
        logic [3:0]  vcopt;
        logic        crop_en;
        logic        rsvd_40;
        logic [1:0]  user_mode;
        logic        db15_en;
        logic [16:0] rsvd_36;
        logic        osd60;
        logic [12:0] rsvd_18;
        logic [2:0]  scan_fx;
        logic [2:0]  rsvd_2;
    } mr_status_fld_t;

    // Same word seen flat or by field
    typedef union packed {
        logic [STATUS_W-1:0] raw;
        mr_status_fld_t      fld;
    } mr_status_u;

endpackage

/* hw/mr_status_ctrl.sv */
/* Splits the OSD status word into settings for the datapaths and
   builds the menu visibility mask returned to the HPS. */
`timescale 1ns/1ps

module mr_status_ctrl
    import mr_glue_pkg::*;
(
    input  logic              clk_sys,
    input  logic              rst_n,
    input  mr_status_u        status,
    input  logic [6:0]        core_mod,
    input  logic              direct_video,
    input  logic              crop_ok,

    output logic              crop_en,
    output logic [1:0]        crop_scale,
    output logic [3:0]        vcopt,
    output logic [2:0]        scan_fx,
    output logic              db15_en,
    output logic              uart_en,
    output logic              fb_flip,
    output logic [MENU_W-1:0] status_menumask
);

    logic hsize_en;
    logic flip_req;

    // Vertical crop settings
    assign crop_en    = status.fld.crop_en;
    assign crop_scale = status.fld.crop_scale;
    assign vcopt      = status.fld.vcopt;
    assign scan_fx    = status.fld.scan_fx;

    // Extension port mode
    assign db15_en = status.fld.db15_en;
    // UART shares bit 38 with user_mode, read flat here
    assign uart_en = status.raw[UART_EN_BIT];

    // Horizontal scaler enable, only shown in the menu
    assign hsize_en = status.fld.hsize_en;

    // A high bit hides the matching menu item
    assign status_menumask = {
        {(MENU_W-6){1'b0}},
        crop_ok,
        // Rotate options hidden in this build
        1'b1,
        // Scan FX always available without the 60 Hz option
        1'b1,
        ~hsize_en,
        // Flip option only for vertical games
        ~core_mod[0],
        direct_video
    };

    assign flip_req = (status.fld.user_mode == 2'(FLIP_MODE));

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            fb_flip <= 1'b0;
        end else begin
            fb_flip <= flip_req;
        end
    end

    // Upper mask bits are unused menu slots and must stay visible
    a_menu_upper_zero: assert property (
        @(posedge clk_sys) disable iff (!rst_n)
        status_menumask[MENU_W-1:6] == '0
    );

endmodule

/* hw/mr_crop_ctrl.sv */
/* Vertical crop control for 1080p HDMI output. Decides if cropping is
   allowed and gives the crop size and line offset to the aspect scaler. */
`timescale 1ns/1ps

module mr_crop_ctrl
    import mr_glue_pkg::*;
(
    input  logic                   clk_sys,
    input  logic                   rst_n,
    input  logic [HDMI_DIM_W-1:0]  hdmi_width,
    input  logic [HDMI_DIM_W-1:0]  hdmi_height,
    input  logic [2:0]             scan_fx,
    input  logic                   force_scan2x,
    input  logic [1:0]             crop_scale,
    input  logic                   direct_video,
    input  logic [1:0]             rotate,
    input  logic                   crop_en,
    input  logic [3:0]             vcopt,

    output logic                   crop_ok,
    output logic [CROP_SIZE_W-1:0] crop_size,
    output logic [CROP_OFF_W-1:0]  crop_off
);

    logic                  full_hd;
    logic                  crop_allowed;
    logic [CROP_OFF_W-1:0] vcopt_x2;
    logic [CROP_OFF_W-1:0] off_next;

    assign full_hd = (hdmi_width  == HDMI_DIM_W'(FULL_HD_W)) &&
                     (hdmi_height == HDMI_DIM_W'(FULL_HD_H));

    // Scan FX, forced scan doubler, integer scaling, direct video and
    // rotation all rule out cropping
    assign crop_allowed = full_hd && (scan_fx == '0) && !force_scan2x &&
                          (crop_scale == '0) && !direct_video && !rotate[0];

    // Two lines per vcopt step, upper steps wrap to negative offsets
    assign vcopt_x2 = {vcopt, 1'b0};
    assign off_next = (vcopt < VCOPT_WRAP) ? vcopt_x2
                                           : vcopt_x2 - CROP_OFF_W'(VCOPT_BIAS);

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            crop_ok   <= 1'b0;
            crop_off  <= '0;
            crop_size <= '0;
        end else begin
            crop_ok  <= crop_allowed;
            crop_off <= off_next;
            // Uses the eligibility from the previous cycle
            crop_size <= (crop_ok && crop_en) ? CROP_SIZE_W'(CROP_LINES) : '0;
        end
    end

    a_size_values: assert property (
        @(posedge clk_sys) disable iff (!rst_n)
        (crop_size == '0) || (crop_size == CROP_SIZE_W'(CROP_LINES))
    );

    // No crop without eligibility seen one cycle before
    a_size_needs_ok: assert property (
        @(posedge clk_sys) disable iff (!rst_n)
        (crop_size != '0) |-> $past(crop_ok)
    );

endmodule

/* hw/mr_player_io.sv */
/* Player input glue. Drives the extension port as DB15 joystick link,
   UART or idle, and decodes the PS/2 mouse packet from the HPS. */
`timescale 1ns/1ps

module mr_player_io
    import mr_glue_pkg::*;
(
    input  logic                   clk_sys,
    input  logic                   rst_n,
    input  logic                   db15_en,
    input  logic                   uart_en,
    input  logic [USER_W-1:0]      joy_out,
    input  logic                   cheat_tx,
    input  logic                   game_tx,
    input  logic [USER_W-1:0]      user_in,
    output logic [USER_W-1:0]      user_out,
    output logic                   game_rx,

    input  logic [MOUSE_PKT_W-1:0] ps2_mouse,
    output logic [MOUSE_D_W-1:0]   mouse_dx,
    output logic [MOUSE_D_W-1:0]   mouse_dy,
    output logic [MOUSE_F_W-1:0]   mouse_flags,
    output logic                   mouse_st
);

    logic [USER_W-1:0] user_next;
    logic              uart_tx;
    logic              mouse_tog;
    logic              mouse_tog_q;

    // Cheat engine and game UARTs share the TX line, either can pull low
    assign uart_tx = cheat_tx & game_tx;

    // DB15 first, then UART, otherwise all pins released high
    always_comb begin
        if (db15_en) begin
            user_next = joy_out;
        end else if (uart_en) begin
            user_next = {{(USER_W-1){1'b1}}, uart_tx};
        end else begin
            user_next = USER_IDLE;
        end
    end

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            user_out <= USER_IDLE;
        end else begin
            user_out <= user_next;
        end
    end

    // RX idles high when the UART is off
    assign game_rx = uart_en ? user_in[UART_RX_BIT] : 1'b1;

    // Packet: flags 7:0, dx 15:8, dy 23:16, toggle on top
    assign mouse_flags = ps2_mouse[MOUSE_F_W-1:0];
    assign mouse_tog   = ps2_mouse[MOUSE_PKT_W-1];

    // Sign bits for dx and dy live in flags 4 and 5
    assign mouse_dx = {mouse_flags[4], ps2_mouse[15:8]};
    assign mouse_dy = {mouse_flags[5], ps2_mouse[23:16]};

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            mouse_tog_q <= 1'b0;
        end else begin
            mouse_tog_q <= mouse_tog;
        end
    end

    // New packet strobe on every toggle change
    assign mouse_st = mouse_tog ^ mouse_tog_q;

    // One packet gives one strobe, a steady packet cannot strobe again
    a_mouse_st_single: assert property (
        @(posedge clk_sys) disable iff (!rst_n)
        mouse_st |=> !(mouse_st && $stable(ps2_mouse))
    );

endmodule

/* hw/mr_glue_top.sv */
/* Top of the settings and player-input glue around the arcade core.
   Connects status decode, crop control and player I/O. */
`timescale 1ns/1ps

module mr_glue_top
    import mr_glue_pkg::*;
(
    input  logic                   clk_sys,
    input  logic                   rst_n,

    // Settings from the HPS
    input  logic [STATUS_W-1:0]    status,
    input  logic [6:0]             core_mod,
    input  logic                   direct_video,
    input  logic                   force_scan2x,
    input  logic [1:0]             rotate,
    input  logic [HDMI_DIM_W-1:0]  hdmi_width,
    input  logic [HDMI_DIM_W-1:0]  hdmi_height,

    // Extension port
    input  logic [USER_W-1:0]      joy_out,
    input  logic                   cheat_tx,
    input  logic                   game_tx,
    input  logic [USER_W-1:0]      user_in,

    input  logic [MOUSE_PKT_W-1:0] ps2_mouse,

    output logic [MENU_W-1:0]      status_menumask,
    output logic                   fb_flip,
    output logic [CROP_SIZE_W-1:0] crop_size,
    output logic [CROP_OFF_W-1:0]  crop_off,
    output logic [USER_W-1:0]      user_out,
    output logic                   game_rx,
    output logic [MOUSE_D_W-1:0]   mouse_dx,
    output logic [MOUSE_D_W-1:0]   mouse_dy,
    output logic [MOUSE_F_W-1:0]   mouse_flags,
    output logic                   mouse_st
);

    mr_status_u status_u;

    logic       crop_en;
    logic [1:0] crop_scale;
    logic [3:0] vcopt;
    logic [2:0] scan_fx;
    logic       db15_en;
    logic       uart_en;
    logic       crop_ok;

    assign status_u.raw = status;

    mr_status_ctrl i_status_ctrl (
        .clk_sys         ( clk_sys         ),
        .rst_n           ( rst_n           ),
        .status          ( status_u        ),
        .core_mod        ( core_mod        ),
        .direct_video    ( direct_video    ),
        .crop_ok         ( crop_ok         ),
        .crop_en         ( crop_en         ),
        .crop_scale      ( crop_scale      ),
        .vcopt           ( vcopt           ),
        .scan_fx         ( scan_fx         ),
        .db15_en         ( db15_en         ),
        .uart_en         ( uart_en         ),
        .fb_flip         ( fb_flip         ),
        .status_menumask ( status_menumask )
    );

    mr_crop_ctrl i_crop_ctrl (
        .clk_sys      ( clk_sys      ),
        .rst_n        ( rst_n        ),
        .hdmi_width   ( hdmi_width   ),
        .hdmi_height  ( hdmi_height  ),
        .scan_fx      ( scan_fx      ),
        .force_scan2x ( force_scan2x ),
        .crop_scale   ( crop_scale   ),
        .direct_video ( direct_video ),
        .rotate       ( rotate       ),
        .crop_en      ( crop_en      ),
        .vcopt        ( vcopt        ),
        .crop_ok      ( crop_ok      ),
        .crop_size    ( crop_size    ),
        .crop_off     ( crop_off     )
    );

    mr_player_io i_player_io (
        .clk_sys     ( clk_sys     ),
        .rst_n       ( rst_n       ),
        .db15_en     ( db15_en     ),
        .uart_en     ( uart_en     ),
        .joy_out     ( joy_out     ),
        .cheat_tx    ( cheat_tx    ),
        .game_tx     ( game_tx     ),
        .user_in     ( user_in     ),
        .user_out    ( user_out    ),
        .game_rx     ( game_rx     ),
        .ps2_mouse   ( ps2_mouse   ),
        .mouse_dx    ( mouse_dx    ),
        .mouse_dy    ( mouse_dy    ),
        .mouse_flags ( mouse_flags ),
        .mouse_st    ( mouse_st    )
    );

endmodule

/* verification/mr_glue_tb.sv */
/* Self-checking testbench for mr_glue_top. Drives LCG random settings, port
   and mouse traffic and compares every output with a cycle model. */
`timescale 1ns/1ps

module mr_glue_tb;
    import mr_glue_pkg::*;

    localparam int CLK_HALF      = 20;
    localparam int DRIVE_DELAY   = 2;
    localparam int RESET_CYCLES  = 8;
    localparam int RANDOM_CYCLES = 3000;
    localparam int WAIT_LIMIT    = 8;

    logic                   clk_sys;
    logic                   rst_n;
    logic [STATUS_W-1:0]    status;
    logic [6:0]             core_mod;
    logic                   direct_video;
    logic                   force_scan2x;
    logic [1:0]             rotate;
    logic [HDMI_DIM_W-1:0]  hdmi_width;
    logic [HDMI_DIM_W-1:0]  hdmi_height;
    logic [USER_W-1:0]      joy_out;
    logic                   cheat_tx;
    logic                   game_tx;
    logic [USER_W-1:0]      user_in;
    logic [MOUSE_PKT_W-1:0] ps2_mouse;

    logic [MENU_W-1:0]      status_menumask;
    logic                   fb_flip;
    logic [CROP_SIZE_W-1:0] crop_size;
    logic [CROP_OFF_W-1:0]  crop_off;
    logic [USER_W-1:0]      user_out;
    logic                   game_rx;
    logic [MOUSE_D_W-1:0]   mouse_dx;
    logic [MOUSE_D_W-1:0]   mouse_dy;
    logic [MOUSE_F_W-1:0]   mouse_flags;
    logic                   mouse_st;

    // Model state, one and two cycles behind the inputs
    logic [USER_W-1:0]      m_user_out;
    logic                   m_crop_ok;
    logic [CROP_SIZE_W-1:0] m_crop_size;
    logic [CROP_OFF_W-1:0]  m_crop_off;
    logic                   m_fb_flip;
    logic                   m_tog_q;

    logic [31:0] lcg_state;

    mr_glue_top i_dut (
        .clk_sys         ( clk_sys         ),
        .rst_n           ( rst_n           ),
        .status          ( status          ),
        .core_mod        ( core_mod        ),
        .direct_video    ( direct_video    ),
        .force_scan2x    ( force_scan2x    ),
        .rotate          ( rotate          ),
        .hdmi_width      ( hdmi_width      ),
        .hdmi_height     ( hdmi_height     ),
        .joy_out         ( joy_out         ),
        .cheat_tx        ( cheat_tx        ),
        .game_tx         ( game_tx         ),
        .user_in         ( user_in         ),
        .ps2_mouse       ( ps2_mouse       ),
        .status_menumask ( status_menumask ),
        .fb_flip         ( fb_flip         ),
        .crop_size       ( crop_size       ),
        .crop_off        ( crop_off        ),
        .user_out        ( user_out        ),
        .game_rx         ( game_rx         ),
        .mouse_dx        ( mouse_dx        ),
        .mouse_dy        ( mouse_dy        ),
        .mouse_flags     ( mouse_flags     ),
        .mouse_st        ( mouse_st        )
    );

    initial begin
        clk_sys = 1'b0;
        forever begin
            #(CLK_HALF) clk_sys = ~clk_sys;
        end
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic stop_run(input string what);
        $display("%s", what);
        $display("TEST FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_user(input string name, input logic [USER_W-1:0] exp,
                              input logic [USER_W-1:0] act);
        if (act !== exp) begin
            $display("ERR %s: expected %h, actual %h", name, exp, act);
            stop_run("user port mismatch");
        end
    endtask

    task automatic check_menu(input string name, input logic [MENU_W-1:0] exp,
                              input logic [MENU_W-1:0] act);
        if (act !== exp) begin
            $display("ERR %s: expected %h, actual %h", name, exp, act);
            stop_run("menu mask mismatch");
        end
    endtask

    task automatic check_crop(input string name, input logic [CROP_SIZE_W-1:0] exp,
                              input logic [CROP_SIZE_W-1:0] act);
        if (act !== exp) begin
            $display("ERR %s: expected %h, actual %h", name, exp, act);
            stop_run("crop size mismatch");
        end
    endtask

    task automatic check_offset(input string name, input logic [CROP_OFF_W-1:0] exp,
                                input logic [CROP_OFF_W-1:0] act);
        if (act !== exp) begin
            $display("ERR %s: expected %h, actual %h", name, exp, act);
            stop_run("crop offset mismatch");
        end
    endtask

    task automatic check_mouse(input string name, input logic [MOUSE_D_W-1:0] exp,
                               input logic [MOUSE_D_W-1:0] act);
        if (act !== exp) begin
            $display("ERR %s: expected %h, actual %h", name, exp, act);
            stop_run("mouse delta mismatch");
        end
    endtask

    task automatic check_flags(input string name, input logic [MOUSE_F_W-1:0] exp,
                               input logic [MOUSE_F_W-1:0] act);
        if (act !== exp) begin
            $display("ERR %s: expected %h, actual %h", name, exp, act);
            stop_run("mouse flags mismatch");
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERR %s: expected %b, actual %b", name, exp, act);
            stop_run("single bit output mismatch");
        end
    endtask

    // Loads the model registers with the inputs seen at this clock edge
    task automatic advance_model();
        mr_status_u sv;
        int         v;
        sv.raw = status;
        // Size is built from the eligibility of the previous cycle
        m_crop_size = (m_crop_ok && sv.fld.crop_en) ? CROP_SIZE_W'(CROP_LINES) : '0;
        m_crop_ok = (hdmi_width == HDMI_DIM_W'(FULL_HD_W)) &&
                    (hdmi_height == HDMI_DIM_W'(FULL_HD_H)) &&
                    (sv.fld.scan_fx == 3'd0) && !force_scan2x &&
                    (sv.fld.crop_scale == 2'd0) && !direct_video && !rotate[0];
        v = sv.fld.vcopt;
        if (v < VCOPT_WRAP) begin
            m_crop_off = CROP_OFF_W'(2 * v);
        end else begin
            m_crop_off = CROP_OFF_W'(2 * v - VCOPT_BIAS);
        end
        m_fb_flip = (sv.fld.user_mode == 2'(FLIP_MODE));
        if (sv.fld.db15_en) begin
            m_user_out = joy_out;
        end else if (sv.fld.user_mode[0]) begin
            m_user_out = {6'b111111, cheat_tx & game_tx};
        end else begin
            m_user_out = USER_IDLE;
        end
        m_tog_q = ps2_mouse[MOUSE_PKT_W-1];
    endtask

    task automatic clock_edge();
        @(posedge clk_sys);
        advance_model();
        #(DRIVE_DELAY);
    endtask

    // Samples at the falling edge, well away from input changes
    task automatic sample_and_check(input string name);
        mr_status_u        sv;
        logic [MENU_W-1:0] menu;
        logic              rx;
        @(negedge clk_sys);
        sv.raw = status;
        rx = sv.fld.user_mode[0] ? user_in[UART_RX_BIT] : 1'b1;
        menu = '0;
        menu[5] = m_crop_ok;
        menu[4] = 1'b1;
        menu[3] = 1'b1;
        menu[2] = ~sv.fld.hsize_en;
        menu[1] = ~core_mod[0];
        menu[0] = direct_video;
        check_user({name, " user_out"}, m_user_out, user_out);
        check_bit({name, " game_rx"}, rx, game_rx);
        check_menu({name, " menumask"}, menu, status_menumask);
        check_bit({name, " fb_flip"}, m_fb_flip, fb_flip);
        check_crop({name, " crop_size"}, m_crop_size, crop_size);
        check_offset({name, " crop_off"}, m_crop_off, crop_off);
        check_mouse({name, " mouse_dx"}, {ps2_mouse[4], ps2_mouse[15:8]}, mouse_dx);
        check_mouse({name, " mouse_dy"}, {ps2_mouse[5], ps2_mouse[23:16]}, mouse_dy);
        check_flags({name, " mouse_flags"}, ps2_mouse[7:0], mouse_flags);
        check_bit({name, " mouse_st"}, ps2_mouse[MOUSE_PKT_W-1] ^ m_tog_q, mouse_st);
    endtask

    task automatic drive_random();
        mr_status_u  sv;
        logic [31:0] r;
        sv.raw = {lcg_next(), lcg_next()};
        r = lcg_next();
        // Bias toward settings that permit cropping
        if (r[0]) begin
            sv.fld.scan_fx    = 3'd0;
            sv.fld.crop_scale = 2'd0;
        end
        status = sv.raw;
        if (r[1]) begin
            hdmi_width  = HDMI_DIM_W'(FULL_HD_W);
            hdmi_height = HDMI_DIM_W'(FULL_HD_H);
        end else begin
            hdmi_width  = r[15:4];
            hdmi_height = r[27:16];
        end
        r = lcg_next();
        direct_video = (r[2:0] == 3'd0);
        force_scan2x = (r[5:3] == 3'd0);
        rotate       = {r[6], r[9:7] == 3'd0};
        core_mod     = r[16:10];
        joy_out      = r[23:17];
        user_in      = r[30:24];
        r = lcg_next();
        cheat_tx = (r[1:0] != 2'd0);
        game_tx  = (r[3:2] != 2'd0);
        // Packet held steady a quarter of the time
        if (r[5:4] != 2'd0) begin
            ps2_mouse = r[31:7];
        end
    endtask

    initial begin
        mr_status_u sv;
        int         n;
        lcg_state    = 32'h0b2f534c;
        rst_n        = 1'b0;
        status       = '0;
        core_mod     = '0;
        direct_video = 1'b0;
        force_scan2x = 1'b0;
        rotate       = '0;
        hdmi_width   = '0;
        hdmi_height  = '0;
        joy_out      = '0;
        cheat_tx     = 1'b1;
        game_tx      = 1'b1;
        user_in      = '1;
        ps2_mouse    = '0;
        m_user_out   = USER_IDLE;
        m_crop_ok    = 1'b0;
        m_crop_size  = '0;
        m_crop_off   = '0;
        m_fb_flip    = 1'b0;
        m_tog_q      = 1'b0;

        repeat (RESET_CYCLES) @(posedge clk_sys);
        #(DRIVE_DELAY);
        rst_n = 1'b1;
        @(negedge clk_sys);
        check_user("reset user_out", USER_IDLE, user_out);
        check_crop("reset crop_size", '0, crop_size);
        check_offset("reset crop_off", '0, crop_off);
        check_bit("reset fb_flip", 1'b0, fb_flip);
        check_bit("reset mouse_st", 1'b0, mouse_st);

        // Full crop conditions plus a flip request, then wait for both
        clock_edge();
        sv.raw             = '0;
        sv.fld.crop_en     = 1'b1;
        sv.fld.vcopt       = 4'd9;
        sv.fld.user_mode   = 2'(FLIP_MODE);
        status             = sv.raw;
        hdmi_width         = HDMI_DIM_W'(FULL_HD_W);
        hdmi_height        = HDMI_DIM_W'(FULL_HD_H);
        ps2_mouse          = {1'b1, 24'h30a5_11};
        sample_and_check("directed");
        n = 0;
        while (!(crop_size == CROP_SIZE_W'(CROP_LINES) && fb_flip)) begin
            if (n == WAIT_LIMIT) begin
                stop_run("Timeout: crop size and frame flip never became active");
            end
            clock_edge();
            sample_and_check("directed wait");
            n++;
        end

        for (int i = 0; i < RANDOM_CYCLES; i++) begin
            clock_edge();
            drive_random();
            sample_and_check("random");
        end

        $display("TEST PASS");
        $finish;
    end

endmodule

/* compile.f */
hw/mr_glue_pkg.sv
hw/mr_status_ctrl.sv
hw/mr_crop_ctrl.sv
hw/mr_player_io.sv
hw/mr_glue_top.sv
verification/mr_glue_tb.sv

/* Bender.yml */
package:
  name: mr_glue

sources:
  # Package first, then the leaf modules and the top level
  - files:
      - hw/mr_glue_pkg.sv
      - hw/mr_status_ctrl.sv
      - hw/mr_crop_ctrl.sv
      - hw/mr_player_io.sv
      - hw/mr_glue_top.sv

  # Testbench
  - target: test
    files:
      - verification/mr_glue_tb.sv
